// File: include/bp_settings.svh
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// pc is word addressed, so no byte offset bits
`define BP_PC_W 10

// set index comes from the low pc bits
`define BP_SET_W 4

// remaining upper pc bits form the tag
`define BP_TAG_W (`BP_PC_W - `BP_SET_W)

// 4 ways per set, 64 entries in total
`define BP_WAYS 4
`define BP_WAY_W $clog2(`BP_WAYS)

// initial counter on install
// branches start weakly not taken, jumps strongly taken
`define BP_CNT_BRANCH 2'b01
`define BP_CNT_JUMP 2'b11

`endif

// File: list.f
+incdir+include
verilog/bp_pkg.sv
verilog/branch_resolve.sv
verilog/bht_lookup.sv
verilog/bht_store.sv
verilog/flush_ctrl.sv
verilog/branch_predictor.sv
verif/branch_predictor_assertions.sv
verif/branch_predictor_tb.sv

// File: run_sim.sh
#!/bin/bash
# builds and runs the branch predictor testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
	--top-module branch_predictor_tb -o branch_predictor_sim > build.log 2>&1 \
	&& ./obj_dir/branch_predictor_sim > sim.log 2>&1 \
	|| echo "SIMULATION FAILED: build or run aborted" >> sim.log

cat build.log sim.log

# the testbench prints the fail message on a failed check or a timeout
if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0

// File: verif/branch_predictor_assertions.sv
`timescale 1ns/1ps

module branch_predictor_assertions (
	input logic CLK,
	input logic nrst,
	input logic mispredict,
	// delayed flush register of the flush controller
	input logic flush_pend,
	input logic flush,
	input bp_pkg::btype_t exe_btype,
	input bp_pkg::correction_t exe_correction
);

	// a misprediction outside the delayed flush cycle flushes once more next cycle
	a_mispredict_flush: assert property (
		@(posedge CLK) disable iff (!nrst) (mispredict && !flush_pend) |=> flush
	) else $error("flush missing one cycle after a misprediction");

	// no pc correction without a branch in exe
	a_idle_correction: assert property (
		@(posedge CLK) disable iff (!nrst)
			(exe_btype == '0) |-> (exe_correction == bp_pkg::CORR_NONE)
	) else $error("correction code set without a branch in exe");

	// delayed flush register is cleared from the first reset edge on
	a_reset_flush: assert property (
		@(posedge CLK) (!nrst && $past(!nrst)) |-> !flush
	) else $error("flush high during reset");

endmodule

bind branch_predictor branch_predictor_assertions branch_predictor_assertions_i (
	.CLK(CLK),
	.nrst(nrst),
	.mispredict(mispredict),
	.flush_pend(flush_ctrl_i.flush_pend),
	.flush(flush),
	.exe_btype(exe_btype),
	.exe_correction(exe_correction)
);

// File: verif/branch_predictor_tb.sv
`timescale 1ns/1ps

`include "bp_settings.svh"

module branch_predictor_tb;

	// directed test lengths plus the random run in clock cycles
	localparam int RANDOM_CYCLES = 400;
	localparam int TOTAL_CYCLES = 4 + 6 + 6 + 13 + 10 + 8 + RANDOM_CYCLES;
	localparam int TIMEOUT_NS = TOTAL_CYCLES * 10 + 1000;

	// fixed pcs of the directed tests in sets of their own
	localparam logic [`BP_PC_W-1:0] PC_BR = 10'h013;
	localparam logic [`BP_PC_W-1:0] PC_JMP = 10'h0a7;
	localparam logic [`BP_PC_W-1:0] PC_MIS = 10'h0c9;
	// exe outcomes of the counter test with the lsb first
	localparam logic [11:0] OUTCOMES = 12'b0110_1000_0111;

	// expected dut outputs of one cycle
	typedef struct packed {
		logic pred;
		logic [`BP_PC_W-1:0] pbt;
		logic [1:0] corr;
		logic [`BP_PC_W-1:0] epbt;
		logic [`BP_PC_W-1:0] cni;
		logic flush;
		logic jib;
	} expect_t;

	logic CLK;
	logic nrst;
	logic [`BP_PC_W-1:0] if_pc, id_pc, id_branch_target, exe_pc;
	logic id_is_jump, id_is_btype, exe_z, exe_less;
	bp_pkg::btype_t exe_btype;
	logic if_prediction, flush, id_jump_in_bht;
	logic [`BP_PC_W-1:0] if_pbt, exe_pbt, exe_cni;
	bp_pkg::correction_t exe_correction;

	// reference model with its own table, fifo pointers and delayed flush
	bp_pkg::bht_entry_t ref_mem [1 << `BP_SET_W][`BP_WAYS];
	logic [`BP_WAY_W-1:0] ref_ptr [1 << `BP_SET_W];
	logic ref_pend;

	logic [15:0] lfsr = 16'd37129;
	string cur_test = "reset";
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int test_fail = 0;
	int err_at_start = 0;

	branch_predictor branch_predictor_i (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	////////////////////
	// random source
	////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic take_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [9:0] take_bits(input int n);
		logic [9:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[8:0], take_bit()};
		end
		return v;
	endfunction

	// 8 tags over 4 sets keeps the hit rate high
	function automatic logic [`BP_PC_W-1:0] pool_pc();
		logic [9:0] r_tag;
		logic [9:0] r_set;
		r_tag = take_bits(3);
		r_set = take_bits(2);
		return {3'b000, r_tag[2:0], 2'b00, r_set[1:0]};
	endfunction

	////////////////////
	// reference model
	////////////////////

	// only a single valid match hits and anything else reads as an all-zero entry
	function automatic void ref_lookup(input logic [`BP_PC_W-1:0] pc, output logic hit,
			output logic [`BP_WAY_W-1:0] way, output bp_pkg::bht_entry_t ent);
		int n;
		n = 0;
		way = '0;
		ent = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (ref_mem[pc[`BP_SET_W-1:0]][w].valid
					&& ref_mem[pc[`BP_SET_W-1:0]][w].tag == pc[`BP_PC_W-1:`BP_SET_W]) begin
				n++;
				way = w[`BP_WAY_W-1:0];
				ent = ref_mem[pc[`BP_SET_W-1:0]][w];
			end
		end
		hit = (n == 1);
		if (!hit) begin
			way = '0;
			ent = '0;
		end
	endfunction

	// outcome per one-hot branch type in beq..bgeu order
	function automatic logic branch_taken();
		case (exe_btype)
			6'b100000: return exe_z;
			6'b010000: return !exe_z;
			6'b001000, 6'b000010: return exe_less;
			6'b000100, 6'b000001: return !exe_less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic expect_t expected_outputs();
		expect_t e;
		logic hit;
		logic id_hit;
		logic misp;
		logic [`BP_WAY_W-1:0] way;
		bp_pkg::bht_entry_t ent;
		ref_lookup(if_pc, hit, way, ent);
		e.pred = ent.cnt[1];
		e.pbt = ent.target;
		ref_lookup(exe_pc, hit, way, ent);
		misp = (|exe_btype) && (branch_taken() != ent.cnt[1]);
		if (!misp) begin
			e.corr = bp_pkg::CORR_NONE;
		end else begin
			e.corr = branch_taken() ? bp_pkg::CORR_PBT : bp_pkg::CORR_CNI;
		end
		e.epbt = ent.target;
		e.cni = exe_pc + 10'd1;
		ref_lookup(id_pc, id_hit, way, ent);
		e.flush = ref_pend || misp;
		e.jib = id_is_jump && id_hit;
		return e;
	endfunction

	function automatic void model_reset();
		for (int s = 0; s < (1 << `BP_SET_W); s++) begin
			ref_ptr[s] = '0;
			for (int w = 0; w < `BP_WAYS; w++) begin
				ref_mem[s][w] = '0;
			end
		end
		ref_pend = 1'b0;
	endfunction

	// state after the coming rising edge
	function automatic void model_update();
		logic id_hit;
		logic exe_hit;
		logic taken;
		logic misp;
		logic [`BP_WAY_W-1:0] id_way;
		logic [`BP_WAY_W-1:0] exe_way;
		logic [`BP_SET_W-1:0] s;
		bp_pkg::bht_entry_t ent;
		bp_pkg::bht_entry_t exe_ent;
		ref_lookup(id_pc, id_hit, id_way, ent);
		ref_lookup(exe_pc, exe_hit, exe_way, exe_ent);
		taken = branch_taken();
		misp = (|exe_btype) && (taken != exe_ent.cnt[1]);
		// a pending flush never arms another one
		if (ref_pend) begin
			ref_pend = 1'b0;
		end else begin
			ref_pend = misp || (id_is_jump && !id_hit);
		end
		s = id_pc[`BP_SET_W-1:0];
		if ((id_is_btype || id_is_jump) && !id_hit) begin
			ent.valid = 1'b1;
			ent.tag = id_pc[`BP_PC_W-1:`BP_SET_W];
			ent.target = id_branch_target;
			ent.cnt = id_is_jump ? `BP_CNT_JUMP : `BP_CNT_BRANCH;
			ref_mem[s][ref_ptr[s]] = ent;
			ref_ptr[s] = ref_ptr[s] + 2'd1;
		end else if (|exe_btype) begin
			// miss steps way 0 starting from a zero counter
			s = exe_pc[`BP_SET_W-1:0];
			if (taken && exe_ent.cnt != 2'b11) begin
				ref_mem[s][exe_way].cnt = exe_ent.cnt + 2'd1;
			end else if (!taken && exe_ent.cnt != 2'b00) begin
				ref_mem[s][exe_way].cnt = exe_ent.cnt - 2'd1;
			end else begin
				ref_mem[s][exe_way].cnt = exe_ent.cnt;
			end
		end
	endfunction

	////////////////////
	// compare
	////////////////////

	task automatic check(input string sig, input logic [31:0] expv, input logic [31:0] actv);
		check_cnt++;
		if (actv !== expv) begin
			err_cnt++;
			$display("Mismatch %s %s: expected %0h, actual %0h at %0t",
				cur_test, sig, expv, actv, $time);
		end
	endtask

	// outputs settle by mid cycle since inputs move 1 ns after the rising edge
	initial begin : compare_outputs
		expect_t e;
		forever begin
			@(negedge CLK);
			if (!nrst) begin
				model_reset();
			end else begin
				e = expected_outputs();
				check("if_prediction", 32'(e.pred), 32'(if_prediction));
				check("if_pbt", 32'(e.pbt), 32'(if_pbt));
				check("exe_correction", 32'(e.corr), 32'(exe_correction));
				check("exe_pbt", 32'(e.epbt), 32'(exe_pbt));
				check("exe_cni", 32'(e.cni), 32'(exe_cni));
				check("flush", 32'(e.flush), 32'(flush));
				check("id_jump_in_bht", 32'(e.jib), 32'(id_jump_in_bht));
				model_update();
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: tests still running after %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////
	// stimulus helpers
	////////////////////

	task automatic set_idle();
		if_pc = '0;
		id_pc = '0;
		id_branch_target = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = '0;
	endtask

	// step to the next cycle with all inputs back to idle
	task automatic cycle();
		@(posedge CLK);
		#1;
		set_idle();
	endtask

	// branch type k in beq..bgeu order with flags set for the wanted outcome
	task automatic resolve(input int k, input logic taken);
		exe_btype = 6'b100000 >> k;
		exe_z = take_bit();
		exe_less = take_bit();
		case (k)
			0: exe_z = taken;
			1: exe_z = !taken;
			2, 4: exe_less = taken;
			default: exe_less = !taken;
		endcase
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_at_start = err_cnt;
	endtask

	// waits for the check of the last driven cycle
	task automatic end_test();
		@(negedge CLK);
		#1;
		test_cnt++;
		if (err_cnt == err_at_start) begin
			$display("test %s: pass", cur_test);
		end else begin
			test_fail++;
			$display("test %s: fail, %0d errors", cur_test, err_cnt - err_at_start);
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic idle_after_reset();
		begin_test("idle_after_reset");
		for (int i = 0; i < 6; i++) begin
			cycle();
			if_pc = take_bits(10);
			exe_pc = take_bits(10);
		end
		end_test();
	endtask

	task automatic install_entries();
		begin_test("install_entries");
		cycle();
		id_pc = PC_BR;
		id_is_btype = 1'b1;
		id_branch_target = 10'h155;
		cycle();
		if_pc = PC_BR;
		cycle();
		id_pc = PC_JMP;
		id_is_jump = 1'b1;
		id_branch_target = 10'h2c0;
		// delayed flush of the new jump lands here
		cycle();
		if_pc = PC_JMP;
		cycle();
		id_pc = PC_JMP;
		id_is_jump = 1'b1;
		cycle();
		end_test();
	endtask

	task automatic counter_saturation();
		begin_test("counter_saturation");
		for (int i = 0; i < 12; i++) begin
			cycle();
			if_pc = PC_BR;
			exe_pc = PC_BR;
			resolve(i % 6, OUTCOMES[i]);
		end
		cycle();
		if_pc = PC_BR;
		end_test();
	endtask

	task automatic set_eviction();
		begin_test("set_eviction");
		for (int t = 1; t <= 5; t++) begin
			cycle();
			id_pc = {6'(t), 4'h5};
			id_is_btype = 1'b1;
			id_branch_target = 10'(t * 3);
		end
		// tag 1 went out with the fifth install
		for (int t = 1; t <= 5; t++) begin
			cycle();
			if_pc = {6'(t), 4'h5};
		end
		end_test();
	endtask

	task automatic mispredict_flush();
		begin_test("mispredict_flush");
		cycle();
		id_pc = PC_MIS;
		id_is_btype = 1'b1;
		id_branch_target = 10'h3f0;
		// weakly not taken resolves taken
		cycle();
		exe_pc = PC_MIS;
		resolve(0, 1'b1);
		cycle();
		// weakly taken resolves not taken
		cycle();
		exe_pc = PC_MIS;
		resolve(1, 1'b0);
		cycle();
		// install in another set wins over the update
		cycle();
		id_pc = 10'h04d;
		id_is_btype = 1'b1;
		exe_pc = PC_MIS;
		resolve(2, 1'b1);
		cycle();
		if_pc = PC_MIS;
		exe_pc = 10'h3ff;
		cycle();
		end_test();
	endtask

	task automatic random_traffic();
		logic [9:0] r;
		begin_test("random_traffic");
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			cycle();
			if_pc = pool_pc();
			id_pc = pool_pc();
			exe_pc = pool_pc();
			id_branch_target = take_bits(10);
			r = take_bits(2);
			id_is_btype = (r == 10'd1);
			id_is_jump = (r == 10'd2);
			r = take_bits(3);
			if (r < 10'd6) begin
				resolve(int'(r), take_bit());
			end
		end
		end_test();
	endtask

	initial begin
		set_idle();
		nrst = 1'b0;
		repeat (4) @(posedge CLK);
		#1;
		nrst = 1'b1;
		idle_after_reset();
		install_entries();
		counter_saturation();
		set_eviction();
		mispredict_flush();
		random_traffic();
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			test_cnt, test_fail, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/bht_lookup.sv
`timescale 1ns/1ps

`include "bp_settings.svh"

module bht_lookup (
	input bp_pkg::bht_entry_t [`BP_WAYS-1:0] set_entries,
	input logic [`BP_TAG_W-1:0] tag,
	output logic hit,
	output logic [`BP_WAY_W-1:0] way,
	output bp_pkg::bht_entry_t entry
);

	// per-way tag match, qualified by valid
	logic [`BP_WAYS-1:0] match;
	// number of matching ways, one bit wider than the way index
	logic [`BP_WAY_W:0] n_match;
	logic [`BP_WAY_W-1:0] sel_way;

	always_comb begin
		for (int w = 0; w < `BP_WAYS; w++) begin
			match[w] = set_entries[w].valid && (set_entries[w].tag == tag);
		end
	end

	// count matches and remember the last matching way
	always_comb begin
		n_match = '0;
		sel_way = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (match[w]) begin
				n_match = n_match + 1'b1;
				sel_way = w[`BP_WAY_W-1:0];
			end
		end
	end

	// only a single match counts as a hit
	// a multi-match falls back to the all-zero entry, i.e. not taken, target 0
	assign hit = (n_match == 1);
	assign way = hit ? sel_way : '0;
	assign entry = hit ? set_entries[sel_way] : '0;

endmodule

// File: verilog/bht_store.sv
`timescale 1ns/1ps

`include "bp_settings.svh"

module bht_store (
	input logic CLK,
	input logic nrst,
	// set read ports
	input logic [`BP_SET_W-1:0] if_set,
	input logic [`BP_SET_W-1:0] id_set,
	input logic [`BP_SET_W-1:0] exe_set,
	output bp_pkg::bht_entry_t [`BP_WAYS-1:0] if_entries,
	output bp_pkg::bht_entry_t [`BP_WAYS-1:0] id_entries,
	output bp_pkg::bht_entry_t [`BP_WAYS-1:0] exe_entries,
	// id install
	input logic [`BP_TAG_W-1:0] id_tag,
	input logic [`BP_PC_W-1:0] id_branch_target,
	input logic id_is_jump,
	input logic id_is_btype,
	input logic id_hit,
	// exe counter update
	input logic exe_active,
	input logic exe_taken,
	input logic [`BP_WAY_W-1:0] exe_way,
	input bp_pkg::bht_entry_t exe_entry
);

	localparam int N_SETS = 1 << `BP_SET_W;

	// 16 sets x 4 ways
	bp_pkg::bht_entry_t bht_mem [N_SETS][`BP_WAYS];
	// per-set replacement pointer, oldest install first
	logic [`BP_WAY_W-1:0] fifo_ptr [N_SETS];

	logic alloc;
	bp_pkg::bht_entry_t new_entry;
	logic [1:0] next_cnt;

	////////////////////
	// read ports
	////////////////////

	always_comb begin
		for (int w = 0; w < `BP_WAYS; w++) begin
			if_entries[w] = bht_mem[if_set][w];
			id_entries[w] = bht_mem[id_set][w];
			exe_entries[w] = bht_mem[exe_set][w];
		end
	end

	////////////////////
	// write decode
	////////////////////

	// install only what is not in the table yet
	assign alloc = (id_is_btype || id_is_jump) && !id_hit;

	always_comb begin
		new_entry.valid = 1'b1;
		new_entry.tag = id_tag;
		new_entry.target = id_branch_target;
		new_entry.cnt = id_is_jump ? `BP_CNT_JUMP : `BP_CNT_BRANCH;
	end

	// one saturating step toward the real outcome
	// on an exe miss exe_entry is zero, so the step starts from 00
	always_comb begin
		next_cnt = exe_entry.cnt;
		if (exe_taken && exe_entry.cnt != 2'b11) begin
			next_cnt = exe_entry.cnt + 2'b01;
		end else if (!exe_taken && exe_entry.cnt != 2'b00) begin
			next_cnt = exe_entry.cnt - 2'b01;
		end
	end

	// id install wins over the exe update in the same cycle
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < N_SETS; s++) begin
				fifo_ptr[s] <= '0;
				for (int w = 0; w < `BP_WAYS; w++) begin
					bht_mem[s][w] <= '0;
				end
			end
		end else if (alloc) begin
			bht_mem[id_set][fifo_ptr[id_set]] <= new_entry;
			// wraps modulo the way count
			fifo_ptr[id_set] <= fifo_ptr[id_set] + 1'b1;
		end else if (exe_active) begin
			// exe_way is 0 on a miss, only the counter field changes
			bht_mem[exe_set][exe_way].cnt <= next_cnt;
		end
	end

endmodule

// File: verilog/bp_pkg.sv
`include "bp_settings.svh"

package bp_pkg;

	////////////////////
	// table entry
	////////////////////

	// one line of the branch history table, 19 bits
	// cnt[1] is the taken prediction
	typedef struct packed {
		logic valid;
		logic [`BP_TAG_W-1:0] tag;
		logic [`BP_PC_W-1:0] target;
		logic [1:0] cnt;
	} bht_entry_t;

	////////////////////
	// exe pc correction
	////////////////////

	// code 01 is never produced
	typedef enum logic [1:0] {
		CORR_NONE = 2'b00,
		CORR_CNI = 2'b10,
		CORR_PBT = 2'b11
	} correction_t;

	// one-hot branch type from decode
	// all zero means no branch sits in exe
	typedef struct packed {
		logic beq;
		logic bne;
		logic blt;
		logic bge;
		logic bltu;
		logic bgeu;
	} btype_t;

endpackage

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps

`include "bp_settings.svh"

module branch_predictor (
	input logic CLK,
	input logic nrst,
	input logic [`BP_PC_W-1:0] if_pc,
	input logic [`BP_PC_W-1:0] id_pc,
	input logic [`BP_PC_W-1:0] id_branch_target,
	input logic id_is_jump,
	input logic id_is_btype,
	input logic [`BP_PC_W-1:0] exe_pc,
	input logic exe_z,
	input logic exe_less,
	input bp_pkg::btype_t exe_btype,
	output logic if_prediction,
	output logic [`BP_PC_W-1:0] if_pbt,
	output bp_pkg::correction_t exe_correction,
	output logic [`BP_PC_W-1:0] exe_pbt,
	output logic [`BP_PC_W-1:0] exe_cni,
	output logic flush,
	output logic id_jump_in_bht
);

	// pc split, pc = {tag, set}
	logic [`BP_SET_W-1:0] if_set, id_set, exe_set;
	logic [`BP_TAG_W-1:0] if_tag, id_tag, exe_tag;

	bp_pkg::bht_entry_t [`BP_WAYS-1:0] if_entries, id_entries, exe_entries;
	bp_pkg::bht_entry_t if_entry, exe_entry;
	logic id_hit;
	logic [`BP_WAY_W-1:0] exe_way;

	logic exe_active, exe_taken, mispredict;

	assign if_set = if_pc[`BP_SET_W-1:0];
	assign if_tag = if_pc[`BP_PC_W-1:`BP_SET_W];
	assign id_set = id_pc[`BP_SET_W-1:0];
	assign id_tag = id_pc[`BP_PC_W-1:`BP_SET_W];
	assign exe_set = exe_pc[`BP_SET_W-1:0];
	assign exe_tag = exe_pc[`BP_PC_W-1:`BP_SET_W];

	////////////////////
	// table and lookups
	////////////////////

	bht_store bht_store_i (
		.CLK(CLK), .nrst(nrst),
		.if_set(if_set), .id_set(id_set), .exe_set(exe_set),
		.if_entries(if_entries), .id_entries(id_entries), .exe_entries(exe_entries),
		.id_tag(id_tag), .id_branch_target(id_branch_target),
		.id_is_jump(id_is_jump), .id_is_btype(id_is_btype), .id_hit(id_hit),
		.exe_active(exe_active), .exe_taken(exe_taken),
		.exe_way(exe_way), .exe_entry(exe_entry)
	);

	// a miss already gives a zero entry, so if needs no hit flag
	bht_lookup if_lookup_i (
		.set_entries(if_entries), .tag(if_tag),
		.hit(), .way(), .entry(if_entry)
	);

	// id only cares whether the pc is already stored
	bht_lookup id_lookup_i (
		.set_entries(id_entries), .tag(id_tag),
		.hit(id_hit), .way(), .entry()
	);

	bht_lookup exe_lookup_i (
		.set_entries(exe_entries), .tag(exe_tag),
		.hit(), .way(exe_way), .entry(exe_entry)
	);

	////////////////////
	// resolve and flush
	////////////////////

	branch_resolve branch_resolve_i (
		.exe_btype(exe_btype), .exe_z(exe_z), .exe_less(exe_less),
		.predicted(exe_entry.cnt[1]),
		.exe_active(exe_active), .exe_taken(exe_taken),
		.mispredict(mispredict), .correction(exe_correction)
	);

	flush_ctrl flush_ctrl_i (
		.CLK(CLK), .nrst(nrst),
		.mispredict(mispredict), .id_is_jump(id_is_jump), .id_hit(id_hit),
		.flush(flush), .id_jump_in_bht(id_jump_in_bht)
	);

	// prediction comes straight from the counter msb
	assign if_prediction = if_entry.cnt[1];
	assign if_pbt = if_entry.target;
	assign exe_pbt = exe_entry.target;
	// next sequential word after the branch
	assign exe_cni = exe_pc + {{(`BP_PC_W-1){1'b0}}, 1'b1};

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
	input bp_pkg::btype_t exe_btype,
	input logic exe_z,
	input logic exe_less,
	// upper counter bit of the exe entry
	input logic predicted,
	output logic exe_active,
	output logic exe_taken,
	output logic mispredict,
	output bp_pkg::correction_t correction
);

	// any flag set means a branch is resolving this cycle
	assign exe_active = |exe_btype;

	// branch comparison table
	// signed and unsigned forms share the less flag, the alu already picked the compare
	assign exe_taken = (exe_btype.beq && exe_z)
		|| (exe_btype.bne && !exe_z)
		|| ((exe_btype.blt || exe_btype.bltu) && exe_less)
		|| ((exe_btype.bge || exe_btype.bgeu) && !exe_less);

	// counter guessed the wrong direction
	assign mispredict = exe_active && (exe_taken != predicted);

	always_comb begin
		if (!mispredict) begin
			correction = bp_pkg::CORR_NONE;
		end else if (exe_taken) begin
			// should have jumped, go to the stored target
			correction = bp_pkg::CORR_PBT;
		end else begin
			// should have fallen through
			correction = bp_pkg::CORR_CNI;
		end
	end

endmodule

// File: verilog/flush_ctrl.sv
`timescale 1ns/1ps

module flush_ctrl (
	input logic CLK,
	input logic nrst,
	input logic mispredict,
	input logic id_is_jump,
	input logic id_hit,
	output logic flush,
	output logic id_jump_in_bht
);

	// delayed flush, fires one cycle after it is armed
	logic flush_pend;
	logic flush_arm;

	////////////////////
	// flush rules
	////////////////////

	always_comb begin
		if (flush_pend) begin
			// second flush cycle, nothing new gets armed here
			flush = 1'b1;
			flush_arm = 1'b0;
		end else if (mispredict) begin
			// flush now and once more next cycle
			flush = 1'b1;
			flush_arm = 1'b1;
		end else begin
			flush = 1'b0;
			// new jump in id, target only known after install
			flush_arm = id_is_jump && !id_hit;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			flush_pend <= 1'b0;
		end else begin
			flush_pend <= flush_arm;
		end
	end

	// jump already stored, the pc mux can use the if target directly
	assign id_jump_in_bht = id_is_jump && id_hit;

endmodule
